/* Bender.yml */
package:
  name: modbus_slave

sources:
  - files:
      - hdl/modbusPkg.sv
      - hdl/modbusCrc16.sv
      - hdl/modbusFrameReceiver.sv
      - hdl/registerReadCounter.sv
      - hdl/modbusResponder.sv
      - hdl/modbusSlave.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tbModbusSlave.sv

/* hdl/modbusCrc16.sv */
// CRC-16/Modbus over one byte per enable; clear and enable in the same cycle start a new CRC
`default_nettype none

module modbusCrc16 (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        clear,
    input  wire logic        enable,
    input  wire logic [7:0]  data,
    output logic      [15:0] crc
);

    // whole byte in one step, LSB first
    function automatic logic [15:0] crcStep(input logic [15:0] crcIn, input logic [7:0] byteIn);
        logic [15:0] c;
        c = crcIn ^ {8'h00, byteIn};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ 16'hA001) : (c >> 1);
        end
        return c;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            crc <= 16'hFFFF;
        end else if (enable) begin
            crc <= crcStep(clear ? 16'hFFFF : crc, data); // first byte of a frame
        end else if (clear) begin
            crc <= 16'hFFFF;
        end
    end

endmodule

`default_nettype wire

/* hdl/modbusFrameReceiver.sv */
// parses read requests (0x03/0x04) only; a silence gap must separate frames or they are lost
`default_nettype none

module modbusFrameReceiver #(
    parameter logic [7:0] StationAddress = 8'h37,
    parameter int         HoldingCount   = 32,
    parameter int         InputCount     = 32
) (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire modbusPkg::RxByte        rxByte,
    input  wire logic                    dataReceived,
    input  wire logic                    silence,
    input  wire logic [15:0]             rxCrc,
    output logic                         crcClear,
    output logic                         crcEnable,
    output logic                         requestValid,
    output modbusPkg::ModbusRequest      request
);
    import modbusPkg::*;

    typedef enum logic [3:0] {
        RxAddress,
        RxFunction,
        RxStartHi,
        RxStartLo,
        RxQuantityHi,
        RxQuantityLo,
        RxCrcLo,
        RxCrcHi,
        RxWait
    } RxState;

    RxState      state;
    logic [7:0]  crcLow;
    logic        functionSupported;
    RegWord      quantityNow;
    logic [16:0] endAddress;
    logic [16:0] bankLimit;

    assign functionSupported = rxByte.data == ReadHolding || rxByte.data == ReadInput;
    assign quantityNow       = {request.quantity[15:8], rxByte.data};
    assign endAddress        = 17'(request.startAddress) + 17'(quantityNow);
    assign bankLimit         = request.regBank ? 17'(InputCount) : 17'(HoldingCount);

    // CRC covers everything up to the quantity low byte
    assign crcClear  = state == RxAddress;
    assign crcEnable = dataReceived && !silence && !rxByte.parityError
                       && state != RxCrcLo && state != RxCrcHi && state != RxWait;

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= RxAddress;
            requestValid <= 1'b0;
        end else begin
            requestValid <= 1'b0;
            if (silence) begin
                state <= RxAddress;
            end else if (dataReceived) begin
                if (rxByte.parityError) begin
                    state <= RxWait; // whole frame dropped
                end else begin
                    case (state)
                        RxAddress: begin
                            state <= (rxByte.data == StationAddress) ? RxFunction : RxWait;
                        end
                        RxFunction: begin
                            request.funcCode    <= rxByte.data;
                            request.regBank     <= rxByte.data == ReadInput;
                            request.isException <= !functionSupported;
                            request.exception   <= IllegalFunction;
                            if (functionSupported) begin
                                state <= RxStartHi;
                            end else begin
                                requestValid <= 1'b1;
                                state        <= RxWait;
                            end
                        end
                        RxStartHi: begin
                            request.startAddress[15:8] <= rxByte.data;
                            state <= RxStartLo;
                        end
                        RxStartLo: begin
                            request.startAddress[7:0] <= rxByte.data;
                            state <= RxQuantityHi;
                        end
                        RxQuantityHi: begin
                            request.quantity[15:8] <= rxByte.data;
                            state <= RxQuantityLo;
                        end
                        RxQuantityLo: begin
                            request.quantity[7:0] <= rxByte.data;
                            if (quantityNow == 16'd0 || quantityNow > 16'(MaxReadQuantity)) begin
                                request.isException <= 1'b1;
                                request.exception   <= IllegalQuantity;
                                requestValid        <= 1'b1;
                                state               <= RxWait;
                            end else if (endAddress > bankLimit) begin
                                request.isException <= 1'b1;
                                request.exception   <= IllegalAddress;
                                requestValid        <= 1'b1;
                                state               <= RxWait;
                            end else begin
                                state <= RxCrcLo;
                            end
                        end
                        RxCrcLo: begin
                            crcLow <= rxByte.data;
                            state  <= RxCrcHi;
                        end
                        RxCrcHi: begin
                            requestValid <= {rxByte.data, crcLow} == rxCrc; // silent on mismatch
                            state        <= RxAddress;
                        end
                        default: state <= RxWait; // until silence
                    endcase
                end
            end
        end
    end

    // one request per frame
    assert property (@(posedge clk) disable iff (rst) requestValid |=> !requestValid);

endmodule

`default_nettype wire

/* hdl/modbusPkg.sv */
// shared Modbus RTU definitions; registers are fixed at 16 bits and only reads are supported
`default_nettype none

package modbusPkg;

    // one Modbus register
    typedef logic [15:0] RegWord;

    typedef enum logic [7:0] {
        ReadHolding = 8'h03,
        ReadInput   = 8'h04
    } FunctionCode;

    typedef enum logic [7:0] {
        IllegalFunction = 8'h01,
        IllegalAddress  = 8'h02,
        IllegalQuantity = 8'h03
    } ExceptionCode;

    // parsed request, handed from receiver to responder and counter
    typedef struct packed {
        logic [7:0]  funcCode;     // function byte as received
        logic [15:0] startAddress;
        logic [15:0] quantity;
        logic        isException;
        logic [7:0]  exception;
        logic        regBank;      // 1 selects the input bank
    } ModbusRequest;

    // one byte from the UART
    typedef struct packed {
        logic [7:0] data;
        logic       parityError;
    } RxByte;

    // protocol limit for one read request
    localparam int MaxReadQuantity = 125;

    // set in the function byte of an exception reply
    localparam logic [7:0] ExceptionFlag = 8'h80;

endpackage

`default_nettype wire

/* hdl/modbusResponder.sv */
// builds read and exception replies; requests arriving while a reply is in progress are dropped
`default_nettype none

module modbusResponder #(
    parameter logic [7:0] StationAddress = 8'h37
) (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    requestValid,
    input  wire modbusPkg::ModbusRequest request,
    input  wire logic                    wordValid,
    input  wire modbusPkg::RegWord       word,
    input  wire logic                    lastWord,
    input  wire logic                    writeAck,
    input  wire logic [15:0]             txCrc,
    output logic                         readStart,
    output logic                         wordTaken,
    output logic [7:0]                   dataOut,
    output logic                         writeReq,
    output logic                         crcClear,
    output logic                         crcEnable
);
    import modbusPkg::*;

    typedef enum logic [3:0] {
        TxIdle,
        TxStation,
        TxFunction,
        TxException,
        TxByteCount,
        TxWaitWord,
        TxDataHi,
        TxDataLo,
        TxCrcLo,
        TxCrcHi
    } TxState;

    TxState       state;
    TxState       afterState;
    ModbusRequest req;
    logic [7:0]   byteValue;
    logic         byteDone;

    assign byteDone = writeReq && writeAck;

    // CRC runs over every accepted byte except its own two
    assign crcClear  = state == TxIdle;
    assign crcEnable = byteDone && state != TxCrcLo && state != TxCrcHi;

    always_comb begin
        byteValue  = 8'h00;
        afterState = state;
        case (state)
            TxStation: begin
                byteValue  = StationAddress;
                afterState = TxFunction;
            end
            TxFunction: begin
                byteValue  = req.isException ? (req.funcCode | ExceptionFlag) : req.funcCode;
                afterState = req.isException ? TxException : TxByteCount;
            end
            TxException: begin
                byteValue  = req.exception;
                afterState = TxCrcLo;
            end
            TxByteCount: begin
                byteValue  = {req.quantity[6:0], 1'b0};
                afterState = TxWaitWord;
            end
            TxDataHi: begin
                byteValue  = word[15:8];
                afterState = TxDataLo;
            end
            TxDataLo: begin
                byteValue  = word[7:0];
                afterState = lastWord ? TxCrcLo : TxWaitWord;
            end
            TxCrcLo: begin
                byteValue  = txCrc[7:0];
                afterState = TxCrcHi;
            end
            TxCrcHi: begin
                byteValue  = txCrc[15:8];
                afterState = TxIdle;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= TxIdle;
            writeReq  <= 1'b0;
            readStart <= 1'b0;
            wordTaken <= 1'b0;
        end else begin
            readStart <= 1'b0;
            wordTaken <= 1'b0;
            case (state)
                TxIdle: if (requestValid) begin
                    req   <= request;
                    state <= TxStation;
                end
                TxWaitWord: if (wordValid) begin
                    state <= TxDataHi;
                end
                default: begin
                    if (!writeReq) begin
                        dataOut  <= byteValue; // one idle cycle lets the CRC settle
                        writeReq <= 1'b1;
                    end else if (writeAck) begin
                        writeReq  <= 1'b0;
                        state     <= afterState;
                        readStart <= state == TxByteCount;
                        wordTaken <= state == TxDataLo;
                    end
                end
            endcase
        end
    end

    // FIFO sees a stable byte during back-pressure
    assert property (@(posedge clk) disable iff (rst)
        writeReq && !writeAck |=> writeReq && $stable(dataOut));

endmodule

`default_nettype wire

/* hdl/modbusSlave.sv */
// Modbus RTU read-only slave; the UART and the output FIFO share clk with this block
`default_nettype none

module modbusSlave #(
    parameter int                   AddrWidth      = 24,
    parameter logic [7:0]           StationAddress = 8'h37,
    parameter logic [AddrWidth-1:0] HoldingOffset  = 'hA00000,
    parameter logic [AddrWidth-1:0] InputOffset    = 'h100000,
    parameter int                   HoldingCount   = 32,
    parameter int                   InputCount     = 32
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire modbusPkg::RxByte  rxByte,
    input  wire logic              dataReceived,
    input  wire logic              silence,
    input  wire modbusPkg::RegWord wbDatI,
    input  wire logic              wbAck,
    input  wire logic              writeAck,
    output logic [AddrWidth-1:0]   wbAdr,
    output logic                   wbCyc,
    output logic                   wbStb,
    output logic                   wbWe,
    output logic [7:0]             dataOut,
    output logic                   writeReq
);
    import modbusPkg::*;

    ModbusRequest request;
    RegWord       word;
    logic         requestValid;
    logic         readStart;
    logic         wordValid;
    logic         wordTaken;
    logic         lastWord;
    logic [15:0]  rxCrc;
    logic [15:0]  txCrc;
    logic         rxCrcClear;
    logic         rxCrcEnable;
    logic         txCrcClear;
    logic         txCrcEnable;

    modbusFrameReceiver #(
        .StationAddress(StationAddress),
        .HoldingCount  (HoldingCount),
        .InputCount    (InputCount)
    ) u_receiver (
        .clk         (clk),
        .rst         (rst),
        .rxByte      (rxByte),
        .dataReceived(dataReceived),
        .silence     (silence),
        .rxCrc       (rxCrc),
        .crcClear    (rxCrcClear),
        .crcEnable   (rxCrcEnable),
        .requestValid(requestValid),
        .request     (request)
    );

    modbusCrc16 u_rxCrc (
        .clk   (clk),
        .rst   (rst),
        .clear (rxCrcClear),
        .enable(rxCrcEnable),
        .data  (rxByte.data),
        .crc   (rxCrc)
    );

    registerReadCounter #(
        .AddrWidth    (AddrWidth),
        .HoldingOffset(HoldingOffset),
        .InputOffset  (InputOffset)
    ) u_counter (
        .clk      (clk),
        .rst      (rst),
        .readStart(readStart),
        .request  (request),
        .wordTaken(wordTaken),
        .wbDatI   (wbDatI),
        .wbAck    (wbAck),
        .wbAdr    (wbAdr),
        .wbCyc    (wbCyc),
        .wbStb    (wbStb),
        .wbWe     (wbWe),
        .wordValid(wordValid),
        .word     (word),
        .lastWord (lastWord)
    );

    modbusResponder #(
        .StationAddress(StationAddress)
    ) u_responder (
        .clk         (clk),
        .rst         (rst),
        .requestValid(requestValid),
        .request     (request),
        .wordValid   (wordValid),
        .word        (word),
        .lastWord    (lastWord),
        .writeAck    (writeAck),
        .txCrc       (txCrc),
        .readStart   (readStart),
        .wordTaken   (wordTaken),
        .dataOut     (dataOut),
        .writeReq    (writeReq),
        .crcClear    (txCrcClear),
        .crcEnable   (txCrcEnable)
    );

    modbusCrc16 u_txCrc (
        .clk   (clk),
        .rst   (rst),
        .clear (txCrcClear),
        .enable(txCrcEnable),
        .data  (dataOut),
        .crc   (txCrc)
    );

endmodule

`default_nettype wire

/* hdl/registerReadCounter.sv */
// one Wishbone classic read per register; request must stay unchanged from readStart to last word
`default_nettype none

module registerReadCounter #(
    parameter int                   AddrWidth     = 24,
    parameter logic [AddrWidth-1:0] HoldingOffset = 'hA00000,
    parameter logic [AddrWidth-1:0] InputOffset   = 'h100000
) (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    readStart,
    input  wire modbusPkg::ModbusRequest request,
    input  wire logic                    wordTaken,
    input  wire modbusPkg::RegWord       wbDatI,
    input  wire logic                    wbAck,
    output logic [AddrWidth-1:0]         wbAdr,
    output logic                         wbCyc,
    output logic                         wbStb,
    output logic                         wbWe,
    output logic                         wordValid,
    output modbusPkg::RegWord            word,
    output logic                         lastWord
);
    import modbusPkg::*;

    typedef enum logic [1:0] {CntIdle, CntRead, CntHold} CntState;

    CntState    state;
    logic [6:0] remaining; // quantity never exceeds 125 here

    assign wbWe = 1'b0; // reads only

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= CntIdle;
            wbCyc     <= 1'b0;
            wbStb     <= 1'b0;
            wordValid <= 1'b0;
            lastWord  <= 1'b0;
        end else begin
            wordValid <= 1'b0;
            case (state)
                CntIdle: if (readStart) begin
                    wbAdr     <= (request.regBank ? InputOffset : HoldingOffset)
                                 + AddrWidth'(request.startAddress);
                    remaining <= request.quantity[6:0];
                    wbCyc     <= 1'b1;
                    wbStb     <= 1'b1;
                    state     <= CntRead;
                end
                CntRead: if (wbAck) begin
                    wbCyc     <= 1'b0;
                    wbStb     <= 1'b0;
                    word      <= wbDatI;
                    wordValid <= 1'b1;
                    lastWord  <= remaining == 7'd1;
                    state     <= CntHold;
                end
                default: if (wordTaken) begin // word held until both bytes are out
                    if (lastWord) begin
                        state <= CntIdle;
                    end else begin
                        wbAdr     <= wbAdr + 1'b1;
                        remaining <= remaining - 7'd1;
                        wbCyc     <= 1'b1;
                        wbStb     <= 1'b1;
                        state     <= CntRead;
                    end
                end
            endcase
        end
    end

    // address and strobe held until the slave acks
    assert property (@(posedge clk) disable iff (rst)
        wbStb && !wbAck |=> wbStb && $stable(wbAdr));

endmodule

`default_nettype wire

/* include/modbusTbTasks.svh */
// reply model and compare tasks; include inside tbModbusSlave, which owns the queues and counters
`ifndef MODBUS_TB_TASKS_SVH
`define MODBUS_TB_TASKS_SVH

// CRC-16/Modbus, bit-serial reference
function automatic logic [15:0] crcAddByte(input logic [15:0] crc, input logic [7:0] b);
    logic [15:0] c;
    logic [7:0]  d;
    c = crc;
    d = b;
    for (int i = 0; i < 8; i++) begin
        if (c[0] ^ d[0]) begin
            c = (c >> 1) ^ 16'hA001;
        end else begin
            c = c >> 1;
        end
        d = d >> 1;
    end
    return c;
endfunction

// memory content, mixed from every address bit and the run key
function automatic RegWord memWord(input logic [23:0] addr);
    logic [31:0] mix;
    mix = {8'h00, addr} * 32'h9E3779B1;
    mix = mix ^ (mix >> 13) ^ memKey;
    return mix[15:0];
endfunction

task automatic buildRequest(input logic [7:0] station, input logic [7:0] func,
                            input logic [15:0] start, input logic [15:0] qty);
    logic [47:0] body;
    logic [15:0] crc;
    body = {station, func, start, qty};
    crc  = 16'hFFFF;
    txFrame.delete();
    for (int i = 5; i >= 0; i--) begin
        txFrame.push_back(body[i*8 +: 8]);
        crc = crcAddByte(crc, body[i*8 +: 8]);
    end
    txFrame.push_back(crc[7:0]); // low byte first
    txFrame.push_back(crc[15:8]);
endtask

task automatic closeReply();
    logic [15:0] crc;
    crc = 16'hFFFF;
    foreach (expReply[i]) begin
        crc = crcAddByte(crc, expReply[i]);
    end
    expReply.push_back(crc[7:0]);
    expReply.push_back(crc[15:8]);
endtask

task automatic expectRead(input logic [7:0] func, input logic [15:0] start,
                          input logic [15:0] qty);
    logic [23:0] addr;
    RegWord      w;
    expReply.delete();
    expReply.push_back(Station);
    expReply.push_back(func);
    expReply.push_back(8'(qty * 2));
    for (int i = 0; i < qty; i++) begin
        addr = (func == ReadInput ? InputOffset : HoldingOffset) + 24'(start) + 24'(i);
        w    = memWord(addr);
        expAddr.push_back(addr);
        expReply.push_back(w[15:8]);
        expReply.push_back(w[7:0]);
    end
    closeReply();
endtask

task automatic expectException(input logic [7:0] func, input logic [7:0] code);
    expReply.delete();
    expReply.push_back(Station);
    expReply.push_back(func | ExceptionFlag);
    expReply.push_back(code);
    closeReply();
endtask

task automatic checkByte(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp) begin
        valueErrors++;
        $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic checkWbAddr(input logic [23:0] got, input logic [23:0] exp, input string what);
    if (got !== exp) begin
        valueErrors++;
        $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic checkWord(input RegWord got, input RegWord exp, input string what);
    if (got !== exp) begin
        valueErrors++;
        $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
endtask

`endif

/* tests/tbModbusSlave.sv */
// one request in flight at a time; every frame ends with a silence cycle
`default_nettype none

module tbModbusSlave;
    import modbusPkg::*;

    localparam logic [7:0]  Station       = 8'h37;
    localparam logic [23:0] HoldingOffset = 24'hA00000;
    localparam logic [23:0] InputOffset   = 24'h100000;
    localparam int          Seed          = 27378;
    localparam int          NumFrames     = 42;
    localparam int          TimeoutCycles = 200 * NumFrames;

    logic        clk;
    logic        rst;
    RxByte       rxByte;
    logic        dataReceived;
    logic        silence;
    RegWord      wbDatI;
    logic        wbAck;
    logic        writeAck;
    logic [23:0] wbAdr;
    logic        wbCyc;
    logic        wbStb;
    logic        wbWe;
    logic [7:0]  dataOut;
    logic        writeReq;

    logic [7:0]  txFrame[$];
    logic [7:0]  expReply[$];
    logic [7:0]  rxBytes[$];
    logic [23:0] expAddr[$];
    logic [31:0] memKey;
    logic        busCycle    = 1'b0;
    int          waitCycles  = 0;
    int          valueErrors = 0;
    int          otherErrors = 0;
    int          cycleCount  = 0;

    `include "modbusTbTasks.svh"

    modbusSlave #(
        .AddrWidth     (24),
        .StationAddress(Station),
        .HoldingOffset (HoldingOffset),
        .InputOffset   (InputOffset),
        .HoldingCount  (32),
        .InputCount    (32)
    ) u_modbusSlave (
        .clk         (clk),
        .rst         (rst),
        .rxByte      (rxByte),
        .dataReceived(dataReceived),
        .silence     (silence),
        .wbDatI      (wbDatI),
        .wbAck       (wbAck),
        .writeAck    (writeAck),
        .wbAdr       (wbAdr),
        .wbCyc       (wbCyc),
        .wbStb       (wbStb),
        .wbWe        (wbWe),
        .dataOut     (dataOut),
        .writeReq    (writeReq)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic sendByte(input logic [7:0] data, input logic parityError);
        @(posedge clk);
        #10;
        rxByte       = {data, parityError};
        dataReceived = 1'b1;
        @(posedge clk);
        #10;
        dataReceived = 1'b0;
    endtask

    // first count bytes of txFrame, then a silence cycle
    task automatic sendFrame(input int count, input int parityAt);
        for (int i = 0; i < count; i++) begin
            sendByte(txFrame[i], i == parityAt);
        end
        @(posedge clk);
        #10;
        silence = 1'b1;
        @(posedge clk);
        #10;
        silence = 1'b0;
    endtask

    task automatic awaitReply();
        int last;
        while (rxBytes.size() < expReply.size()) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk); // room for a stray extra byte
        if (rxBytes.size() != expReply.size()) begin
            otherErrors++;
            $display("reply at %0t has %0d bytes instead of %0d", $time, rxBytes.size(),
                     expReply.size());
        end else begin
            last = expReply.size() - 2;
            for (int i = 0; i < 3; i++) begin
                checkByte(rxBytes[i], expReply[i], $sformatf("reply byte %0d", i));
            end
            for (int i = 3; i < last; i += 2) begin
                checkWord({rxBytes[i], rxBytes[i+1]}, {expReply[i], expReply[i+1]},
                          "register word");
            end
            checkWord({rxBytes[last+1], rxBytes[last]}, {expReply[last+1], expReply[last]},
                      "reply CRC");
        end
        if (expAddr.size() != 0) begin
            otherErrors++;
            $display("%0d Wishbone reads never happened, time %0t", expAddr.size(), $time);
        end
        rxBytes.delete();
        expAddr.delete();
    endtask

    task automatic expectNoReply();
        repeat (60) @(posedge clk);
        if (rxBytes.size() != 0) begin
            otherErrors++;
            $display("dropped frame still got %0d reply bytes, time %0t", rxBytes.size(), $time);
            rxBytes.delete();
        end
    endtask

    // Wishbone slave, 0 to 3 wait states
    always @(posedge clk) begin
        #10;
        if (rst || wbAck) begin
            wbAck    = 1'b0;
            busCycle = 1'b0;
        end else if (wbCyc && wbStb) begin
            if (wbWe) begin
                otherErrors++;
                $display("write cycle at %0t where only reads are allowed", $time);
            end
            if (!busCycle) begin
                busCycle   = 1'b1;
                waitCycles = $urandom % 4;
            end
            if (waitCycles != 0) begin
                waitCycles--;
            end else begin
                if (expAddr.size() == 0) begin
                    otherErrors++;
                    $display("unexpected Wishbone read at %h, time %0t", wbAdr, $time);
                end else begin
                    checkWbAddr(wbAdr, expAddr.pop_front(), "Wishbone address");
                end
                wbDatI = memWord(wbAdr);
                wbAck  = 1'b1;
            end
        end
    end

    // output FIFO, accepts about three bytes in four
    always @(posedge clk) begin
        #10;
        writeAck = !rst && ($urandom % 4 != 0);
        if (writeReq && writeAck) begin
            rxBytes.push_back(dataOut);
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TimeoutCycles) begin
            $display("timeout: run did not finish within %0d cycles", TimeoutCycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        int          kind;
        int          parityAt;
        int          idx;
        logic [15:0] start;
        logic [15:0] qty;
        logic [7:0]  func;
        rst          = 1'b1;
        rxByte       = '0;
        dataReceived = 1'b0;
        silence      = 1'b0;
        wbDatI       = '0;
        wbAck        = 1'b0;
        writeAck     = 1'b0;
        memKey       = $urandom(Seed); // seeds the run
        repeat (16) @(posedge clk);
        #10;
        rst = 1'b0;
        for (int f = 0; f < NumFrames; f++) begin
            kind  = f % 7;
            start = 16'($urandom % 32);
            qty   = 16'(1 + $urandom % (32 - start));
            func  = (kind == 1 || (kind > 1 && $urandom % 2)) ? ReadInput : ReadHolding;
            if (kind == 0) begin
                func = ReadHolding;
            end
            case (kind)
                2: begin
                    do begin
                        func = 8'($urandom);
                    end while (func == ReadHolding || func == ReadInput);
                    buildRequest(Station, func, start, qty);
                    expectException(func, IllegalFunction);
                    sendFrame(8, -1);
                    awaitReply();
                end
                3: begin
                    qty = ($urandom % 2) ? 16'd0 : 16'(126 + $urandom % 1000);
                    buildRequest(Station, func, start, qty);
                    expectException(func, IllegalQuantity);
                    sendFrame(8, -1);
                    awaitReply();
                end
                4: begin
                    qty = 16'(33 - start + $urandom % 8); // always past the bank end
                    buildRequest(Station, func, start, qty);
                    expectException(func, IllegalAddress);
                    sendFrame(8, -1);
                    awaitReply();
                end
                5: begin
                    parityAt = -1;
                    buildRequest(Station, func, start, qty);
                    case ($urandom % 3)
                        0: begin
                            idx          = 6 + $urandom % 2;
                            txFrame[idx] = txFrame[idx] ^ 8'(1 + $urandom % 255);
                        end
                        1: buildRequest(Station ^ 8'(1 + $urandom % 255), func, start, qty);
                        default: parityAt = $urandom % 8;
                    endcase
                    sendFrame(8, parityAt);
                    expectNoReply();
                end
                6: begin
                    buildRequest(Station, func, start, qty);
                    expectRead(func, start, qty);
                    sendFrame(1 + $urandom % 7, -1); // cut short by silence
                    sendFrame(8, -1);
                    awaitReply();
                end
                default: begin
                    buildRequest(Station, func, start, qty);
                    expectRead(func, start, qty);
                    sendFrame(8, -1);
                    awaitReply();
                end
            endcase
        end
        $display("run done: %0d value errors, %0d other errors", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+include
hdl/modbusPkg.sv
hdl/modbusCrc16.sv
hdl/modbusFrameReceiver.sv
hdl/registerReadCounter.sv
hdl/modbusResponder.sv
hdl/modbusSlave.sv
tests/tbModbusSlave.sv
